// File: periph_xbar_top.f
periph_xbar_pkg.sv
periph_bus_if.sv
periph_addr_decoder.sv
periph_rr_arbiter.sv
periph_resp_router.sv
periph_error_slave.sv
periph_xbar_top.sv
tb_clk_gen.sv
periph_xbar_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f periph_xbar_top.f --top-module periph_xbar_tb \
		--Mdir obj_dir -o periph_xbar_sim
	./obj_dir/periph_xbar_sim | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: periph_xbar_tb.sv
/*
 * Crossbar testbench: directed routing, decode, error and round-robin tests
 * against simple slave models on every external port
 */
`timescale 1ns/1ps
`default_nettype none

module periph_xbar_tb;
  import periph_xbar_pkg::*;

  // watchdog allows four times the rough test length in cycles
  localparam int TEST_CYCLES     = 500;
  localparam int WATCHDOG_CYCLES = 4 * TEST_CYCLES;

  logic                            clk_i;
  logic                            rst_i;
  logic [5:0]                      cluster_id_i;
  logic [NB_MASTERS-1:0]           m_req_i;
  periph_addr_t [NB_MASTERS-1:0]   m_addr_i;
  logic [NB_MASTERS-1:0]           m_we_n_i;
  periph_be_t [NB_MASTERS-1:0]     m_be_i;
  periph_data_t [NB_MASTERS-1:0]   m_wdata_i;
  logic [NB_MASTERS-1:0]           m_gnt_o;
  logic [NB_MASTERS-1:0]           m_r_valid_o;
  periph_data_t [NB_MASTERS-1:0]   m_r_rdata_o;
  logic [NB_MASTERS-1:0]           m_r_opc_o;
  logic [NB_SLAVES-1:0]            s_req_o;
  periph_addr_t [NB_SLAVES-1:0]    s_addr_o;
  logic [NB_SLAVES-1:0]            s_we_n_o;
  periph_be_t [NB_SLAVES-1:0]      s_be_o;
  periph_data_t [NB_SLAVES-1:0]    s_wdata_o;
  master_id_t [NB_SLAVES-1:0]      s_id_o;
  logic [NB_SLAVES-1:0]            s_gnt_i;
  logic [NB_SLAVES-1:0]            s_r_valid_i = '0;
  periph_data_t [NB_SLAVES-1:0]    s_r_rdata_i = '0;
  logic [NB_SLAVES-1:0]            s_r_opc_i = '0;
  master_id_t [NB_SLAVES-1:0]      s_r_id_i = '0;

  // slave model state captured before each rising edge
  logic [NB_SLAVES-1:0]            gnt_mode;
  logic [NB_SLAVES-1:0]            xfer_seen = '0;
  periph_addr_t [NB_SLAVES-1:0]    seen_addr = '0;
  master_id_t [NB_SLAVES-1:0]      seen_id = '0;

  logic [31:0] lfsr = 32'haa;
  int          errors = 0;
  int          checks = 0;

  tb_clk_gen u_clk_gen (.clk_o(clk_i));

  periph_xbar_top periph_xbar_top_inst (.*);

  assign s_gnt_i = gnt_mode;

  always @(negedge clk_i) begin
    xfer_seen <= s_req_o & s_gnt_i;
    seen_addr <= s_addr_o;
    seen_id   <= s_id_o;
  end

  // answer one cycle after the grant with rdata of address xor slave number
  always @(posedge clk_i) begin
    #2;
    for (int j = 0; j < NB_SLAVES; j++) begin
      s_r_valid_i[j] <= xfer_seen[j];
      s_r_id_i[j]    <= seen_id[j];
      s_r_rdata_i[j] <= seen_addr[j] ^ periph_data_t'(j);
      s_r_opc_i[j]   <= 1'b0;
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
    $display("tests failed");
    $finish;
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  task automatic compare_data(input string name, input periph_data_t exp, input periph_data_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic compare_slot(input string name, input slot_idx_t exp, input slot_idx_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s: expected slot %0d, actual slot %0d", name, exp, act);
    end
  endtask

  task automatic compare_opc(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic compare_we_n(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s: expected we_n %b, actual we_n %b", name, exp, act);
    end
  endtask

  task automatic compare_be(input string name, input periph_be_t exp, input periph_be_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s: expected be %h, actual be %h", name, exp, act);
    end
  endtask

  task automatic compare_gnt(input string name, input master_id_t exp, input master_id_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s: expected mask %b, actual mask %b", name, exp, act);
    end
  endtask

  // lowest raised s_req_o or the error slot when none is raised
  // several raised requests give an index that matches no slot
  function automatic slot_idx_t req_slot();
    slot_idx_t idx;
    int        raised;
    idx    = slot_idx_t'(SLOT_ERR_ID);
    raised = 0;
    for (int j = NB_SLAVES - 1; j >= 0; j--) begin
      if (s_req_o[j]) begin
        idx = slot_idx_t'(j);
        raised++;
      end
    end
    if (raised > 1) begin
      idx = '1;
    end
    return idx;
  endfunction

  function automatic periph_addr_t win_addr(input periph_addr_t base, input int slot,
                                            input logic [31:0] off);
    return base + PERIPH_OFFS + periph_addr_t'(slot << ROUTE_LSB) +
           periph_addr_t'({off[7:0], 2'b00});
  endfunction

  // one transfer from master m that waits for grant and response
  task automatic access(input string name, input int m, input periph_addr_t addr,
                        input slot_idx_t exp_slot, input periph_data_t exp_rdata,
                        input logic exp_opc);
    logic [31:0] rbits;
    master_id_t  mbit;
    int          waited;
    rand_bits(32, rbits);
    mbit = master_id_t'(1 << m);
    @(posedge clk_i);
    #2;
    m_req_i[m]   = 1'b1;
    m_addr_i[m]  = addr;
    m_wdata_i[m] = rbits;
    m_we_n_i[m]  = rbits[0];
    m_be_i[m]    = rbits[4:1];
    waited = 0;
    @(negedge clk_i);
    while (!m_gnt_o[m] && waited < 20) begin
      waited++;
      @(negedge clk_i);
    end
    if (!m_gnt_o[m]) begin
      errors++;
      $display("%s: master %0d was never granted", name, m);
    end else begin
      compare_slot(name, exp_slot, req_slot());
      if (exp_slot < slot_idx_t'(NB_SLAVES)) begin
        compare_gnt(name, mbit, s_id_o[exp_slot]);
        compare_data(name, addr, s_addr_o[exp_slot]);
        compare_data(name, rbits, s_wdata_o[exp_slot]);
        compare_we_n(name, rbits[0], s_we_n_o[exp_slot]);
        compare_be(name, rbits[4:1], s_be_o[exp_slot]);
      end
    end
    @(posedge clk_i);
    #2;
    m_req_i[m] = 1'b0;
    waited = 0;
    @(negedge clk_i);
    while (!m_r_valid_o[m] && waited < 20) begin
      waited++;
      @(negedge clk_i);
    end
    if (!m_r_valid_o[m]) begin
      errors++;
      $display("%s: master %0d got no response", name, m);
    end else begin
      // the response reaches only the requesting master
      compare_gnt(name, mbit, m_r_valid_o);
      compare_data(name, exp_rdata, m_r_rdata_o[m]);
      compare_opc(name, exp_opc, m_r_opc_o[m]);
    end
  endtask

  task automatic test_routing();
    int          slots [5] = '{0, 1, 4, 5, 6};
    logic [31:0] off;
    periph_addr_t a;
    for (int m = 0; m < NB_MASTERS; m++) begin
      foreach (slots[k]) begin
        rand_bits(8, off);
        a = win_addr(CLUSTER_BASE, slots[k], off);
        access("routing", m, a, slot_idx_t'(slots[k]), a ^ slots[k], 1'b0);
      end
    end
  endtask

  task automatic test_eu_alias();
    logic [31:0]  off;
    periph_addr_t a;
    rand_bits(8, off);
    a = win_addr(CLUSTER_BASE, 3, off);
    access("eu_fold", 1, a, slot_idx_t'(SLOT_EU_ID), a ^ SLOT_EU_ID, 1'b0);
    // master 3 last on slot 1 leaves that pointer at 0
    rand_bits(8, off);
    a = win_addr({ALIAS_BASE, 20'h0_0000}, 1, off);
    access("alias", 3, a, slot_idx_t'(1), a ^ 1, 1'b0);
  endtask

  task automatic test_error();
    access("err_high_bit", 0, win_addr(CLUSTER_BASE, 17, 0), slot_idx_t'(SLOT_ERR_ID),
           ERR_RDATA, 1'b1);
    access("err_no_port", 1, win_addr(CLUSTER_BASE, 9, 0), slot_idx_t'(SLOT_ERR_ID),
           ERR_RDATA, 1'b1);
    access("err_ext_slot", 2, win_addr(CLUSTER_BASE, 7, 0), slot_idx_t'(SLOT_ERR_ID),
           ERR_RDATA, 1'b1);
  endtask

  task automatic test_external();
    periph_addr_t base3;
    periph_addr_t a;
    a = win_addr(CLUSTER_BASE + (32'd1 << CLUSTER_ID_SHIFT), 1, 32'h10);
    access("ext_other", 0, a, slot_idx_t'(SLOT_EXT_ID), a ^ SLOT_EXT_ID, 1'b0);
    a = CLUSTER_BASE + 32'h0001_0040;
    access("ext_below", 2, a, slot_idx_t'(SLOT_EXT_ID), a ^ SLOT_EXT_ID, 1'b0);
    @(posedge clk_i);
    #2;
    cluster_id_i = 6'd3;
    base3 = CLUSTER_BASE + (32'd3 << CLUSTER_ID_SHIFT);
    a = win_addr(base3, 4, 32'h20);
    access("cid3_window", 1, a, slot_idx_t'(4), a ^ 4, 1'b0);
    a = win_addr(CLUSTER_BASE, 4, 32'h20);
    access("cid3_old", 1, a, slot_idx_t'(SLOT_EXT_ID), a ^ SLOT_EXT_ID, 1'b0);
    @(posedge clk_i);
    #2;
    cluster_id_i = 6'd0;
  endtask

  task automatic test_round_robin();
    master_id_t  gnt_seen [$];
    master_id_t  prev_gnt;
    logic [31:0] rbits;
    int          cycles;
    @(posedge clk_i);
    #2;
    gnt_mode[1] = 1'b0;
    for (int m = 0; m < NB_MASTERS; m++) begin
      rand_bits(32, rbits);
      m_req_i[m]   = 1'b1;
      m_addr_i[m]  = win_addr(CLUSTER_BASE, 1, m);
      m_wdata_i[m] = rbits;
    end
    // master 0 holds the stalled slave at pointer 0
    repeat (5) begin
      @(negedge clk_i);
      compare_gnt("rr_stall", '0, m_gnt_o);
      compare_slot("rr_stall", slot_idx_t'(1), req_slot());
      compare_data("rr_stall", win_addr(CLUSTER_BASE, 1, 0), s_addr_o[1]);
      compare_gnt("rr_stall", master_id_t'(1), s_id_o[1]);
    end
    @(posedge clk_i);
    #2;
    gnt_mode[1] = 1'b1;
    prev_gnt = '0;
    cycles = 0;
    while (gnt_seen.size() < NB_MASTERS && cycles < 20) begin
      @(negedge clk_i);
      compare_gnt("rr_resp", prev_gnt, m_r_valid_o);
      prev_gnt = m_gnt_o;
      if (prev_gnt != '0) begin
        gnt_seen.push_back(prev_gnt);
      end
      @(posedge clk_i);
      #2;
      m_req_i = m_req_i & ~prev_gnt;
      cycles++;
    end
    @(negedge clk_i);
    compare_gnt("rr_resp", prev_gnt, m_r_valid_o);
    if (gnt_seen.size() != NB_MASTERS) begin
      errors++;
      $display("rr_order: only %0d of %0d masters were granted", gnt_seen.size(), NB_MASTERS);
    end else begin
      for (int k = 0; k < NB_MASTERS; k++) begin
        compare_gnt("rr_order", master_id_t'(1 << k), gnt_seen[k]);
      end
    end
  endtask

  initial begin : main
    rst_i        = 1'b1;
    cluster_id_i = '0;
    m_req_i      = '0;
    m_addr_i     = '0;
    m_we_n_i     = '1;
    m_be_i       = '0;
    m_wdata_i    = '0;
    gnt_mode     = '1;
    repeat (16) @(posedge clk_i);
    #2;
    rst_i = 1'b0;
    test_routing();
    test_eu_alias();
    test_error();
    test_external();
    test_round_robin();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
/*
 * Testbench clock source, free running with a 40 ns period
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  // half period of 20 ns
  always #20 clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: periph_xbar_top.sv
/*
 * Cluster peripheral crossbar: decodes master addresses, arbitrates each
 * slot round-robin and routes tagged responses back to the masters
 */
`timescale 1ns/1ps
`default_nettype none

module periph_xbar_top (
  input  logic                                                       clk_i,
  input  logic                                                       rst_i,
  input  logic [5:0]                                                 cluster_id_i,
  // master side
  input  logic [periph_xbar_pkg::NB_MASTERS-1:0]                     m_req_i,
  input  periph_xbar_pkg::periph_addr_t [periph_xbar_pkg::NB_MASTERS-1:0] m_addr_i,
  input  logic [periph_xbar_pkg::NB_MASTERS-1:0]                     m_we_n_i,
  input  periph_xbar_pkg::periph_be_t [periph_xbar_pkg::NB_MASTERS-1:0]   m_be_i,
  input  periph_xbar_pkg::periph_data_t [periph_xbar_pkg::NB_MASTERS-1:0] m_wdata_i,
  output logic [periph_xbar_pkg::NB_MASTERS-1:0]                     m_gnt_o,
  output logic [periph_xbar_pkg::NB_MASTERS-1:0]                     m_r_valid_o,
  output periph_xbar_pkg::periph_data_t [periph_xbar_pkg::NB_MASTERS-1:0] m_r_rdata_o,
  output logic [periph_xbar_pkg::NB_MASTERS-1:0]                     m_r_opc_o,
  // slave side
  output logic [periph_xbar_pkg::NB_SLAVES-1:0]                      s_req_o,
  output periph_xbar_pkg::periph_addr_t [periph_xbar_pkg::NB_SLAVES-1:0]  s_addr_o,
  output logic [periph_xbar_pkg::NB_SLAVES-1:0]                      s_we_n_o,
  output periph_xbar_pkg::periph_be_t [periph_xbar_pkg::NB_SLAVES-1:0]    s_be_o,
  output periph_xbar_pkg::periph_data_t [periph_xbar_pkg::NB_SLAVES-1:0]  s_wdata_o,
  output periph_xbar_pkg::master_id_t [periph_xbar_pkg::NB_SLAVES-1:0]    s_id_o,
  input  logic [periph_xbar_pkg::NB_SLAVES-1:0]                      s_gnt_i,
  input  logic [periph_xbar_pkg::NB_SLAVES-1:0]                      s_r_valid_i,
  input  periph_xbar_pkg::periph_data_t [periph_xbar_pkg::NB_SLAVES-1:0]  s_r_rdata_i,
  input  logic [periph_xbar_pkg::NB_SLAVES-1:0]                      s_r_opc_i,
  input  periph_xbar_pkg::master_id_t [periph_xbar_pkg::NB_SLAVES-1:0]    s_r_id_i
);
  import periph_xbar_pkg::*;

  periph_bus_if m_bus [NB_MASTERS] ();
  periph_bus_if s_bus [N_SLOTS] ();

  slot_idx_t    [NB_MASTERS-1:0]                m_slot;
  periph_req_t  [NB_MASTERS-1:0]                m_req_data;
  logic         [N_SLOTS-1:0][NB_MASTERS-1:0]   slot_req;
  logic         [N_SLOTS-1:0][NB_MASTERS-1:0]   slot_gnt;
  periph_resp_t [N_SLOTS-1:0]                   slot_resp;
  logic         [N_SLOTS-1:0]                   slot_valid;

  for (genvar i = 0; i < NB_MASTERS; i++) begin : gen_master
    logic [N_SLOTS-1:0] gnt_col;

    assign m_bus[i].req   = m_req_i[i];
    assign m_bus[i].addr  = m_addr_i[i];
    assign m_bus[i].we_n  = m_we_n_i[i];
    assign m_bus[i].be    = m_be_i[i];
    assign m_bus[i].wdata = m_wdata_i[i];
    // one-hot tag identifies the master in every response
    assign m_bus[i].id    = master_id_t'(1 << i);

    periph_addr_decoder u_decoder (
      .addr_i       (m_bus[i].addr),
      .cluster_id_i (cluster_id_i),
      .slot_o       (m_slot[i])
    );

    assign m_req_data[i] = '{addr: m_bus[i].addr, wdata: m_bus[i].wdata,
                             we_n: m_bus[i].we_n, be: m_bus[i].be, id: m_bus[i].id};

    // only the arbiter of the decoded slot can grant this master
    for (genvar j = 0; j < N_SLOTS; j++) begin : gen_gnt_col
      assign gnt_col[j] = slot_gnt[j][i];
    end
    assign m_bus[i].gnt = |gnt_col;

    periph_resp_router u_router (
      .slot_resp_i  (slot_resp),
      .slot_valid_i (slot_valid),
      .master_sel_i (m_bus[i].id),
      .mst          (m_bus[i])
    );

    assign m_gnt_o[i]     = m_bus[i].gnt;
    assign m_r_valid_o[i] = m_bus[i].r_valid;
    assign m_r_rdata_o[i] = m_bus[i].r_rdata;
    assign m_r_opc_o[i]   = m_bus[i].r_opc;
  end

  for (genvar j = 0; j < N_SLOTS; j++) begin : gen_slot
    for (genvar i = 0; i < NB_MASTERS; i++) begin : gen_req_row
      assign slot_req[j][i] = m_bus[i].req && (m_slot[i] == slot_idx_t'(j));
    end

    periph_rr_arbiter u_arbiter (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .req_i      (slot_req[j]),
      .req_data_i (m_req_data),
      .gnt_o      (slot_gnt[j]),
      .slv        (s_bus[j])
    );

    assign slot_resp[j]  = '{rdata: s_bus[j].r_rdata, opc: s_bus[j].r_opc, id: s_bus[j].r_id};
    assign slot_valid[j] = s_bus[j].r_valid;
  end

  // external slave ports
  for (genvar j = 0; j < NB_SLAVES; j++) begin : gen_slave_port
    assign s_req_o[j]   = s_bus[j].req;
    assign s_addr_o[j]  = s_bus[j].addr;
    assign s_we_n_o[j]  = s_bus[j].we_n;
    assign s_be_o[j]    = s_bus[j].be;
    assign s_wdata_o[j] = s_bus[j].wdata;
    assign s_id_o[j]    = s_bus[j].id;

    assign s_bus[j].gnt     = s_gnt_i[j];
    assign s_bus[j].r_valid = s_r_valid_i[j];
    assign s_bus[j].r_rdata = s_r_rdata_i[j];
    assign s_bus[j].r_opc   = s_r_opc_i[j];
    assign s_bus[j].r_id    = s_r_id_i[j];
  end

  periph_error_slave u_error_slave (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .bus   (s_bus[SLOT_ERR_ID])
  );

endmodule

`default_nettype wire

// File: periph_error_slave.sv
/*
 * Error slave: accepts every request at once and answers one cycle later
 * with an error response tagged for the requester
 */
`timescale 1ns/1ps
`default_nettype none

module periph_error_slave (
  input logic         clk_i,
  input logic         rst_i,
  periph_bus_if.slave bus
);
  import periph_xbar_pkg::*;

  logic       valid_q;
  master_id_t id_q;

  // never stalls a master
  assign bus.gnt = 1'b1;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= bus.req;
    end
  end

  // tag of the accepted request, echoed back in the response
  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      id_q <= bus.id;
    end
  end

  assign bus.r_valid = valid_q;
  assign bus.r_rdata = ERR_RDATA;
  assign bus.r_opc   = 1'b1;
  assign bus.r_id    = id_q;

endmodule

`default_nettype wire

// File: periph_resp_router.sv
/*
 * Response router for one master: finds the slot answering this master
 * and forwards its response
 */
`timescale 1ns/1ps
`default_nettype none

module periph_resp_router (
  input  periph_xbar_pkg::periph_resp_t [periph_xbar_pkg::N_SLOTS-1:0] slot_resp_i,
  input  logic [periph_xbar_pkg::N_SLOTS-1:0]                          slot_valid_i,
  input  periph_xbar_pkg::master_id_t                                  master_sel_i,
  periph_bus_if.slave                                                  mst
);
  import periph_xbar_pkg::*;

  logic [N_SLOTS-1:0] hit;
  slot_idx_t          sel;

  // a slot is ours when it answers with our one-hot tag
  for (genvar j = 0; j < N_SLOTS; j++) begin : gen_hit
    assign hit[j] = slot_valid_i[j] && (slot_resp_i[j].id == master_sel_i);
  end

  // one-hot to index, at most one slot answers per cycle
  always_comb begin
    sel = '0;
    for (int j = 0; j < N_SLOTS; j++) begin
      if (hit[j]) begin
        sel = sel | slot_idx_t'(j);
      end
    end
  end

  assign mst.r_valid = |hit;
  assign mst.r_rdata = slot_resp_i[sel].rdata;
  assign mst.r_opc   = slot_resp_i[sel].opc;
  assign mst.r_id    = slot_resp_i[sel].id;

endmodule

`default_nettype wire

// File: periph_rr_arbiter.sv
/*
 * Round-robin arbiter for one slot: picks a requesting master, drives its
 * request onto the slot bus and hands the slot grant back to it
 */
`timescale 1ns/1ps
`default_nettype none

module periph_rr_arbiter (
  input  logic                                                      clk_i,
  input  logic                                                      rst_i,
  input  logic [periph_xbar_pkg::NB_MASTERS-1:0]                    req_i,
  input  periph_xbar_pkg::periph_req_t [periph_xbar_pkg::NB_MASTERS-1:0] req_data_i,
  output logic [periph_xbar_pkg::NB_MASTERS-1:0]                    gnt_o,
  periph_bus_if.master                                              slv
);
  import periph_xbar_pkg::*;

  logic [MASTER_IDX_W-1:0] rr_ptr;
  logic [MASTER_IDX_W-1:0] win_idx;
  logic                    win_valid;
  logic                    xfer;

  // search from the pointer upwards with wrap, lowest distance wins
  always_comb begin : pick_winner
    int cand;
    win_idx   = rr_ptr;
    win_valid = 1'b0;
    for (int k = NB_MASTERS - 1; k >= 0; k--) begin
      cand = int'(rr_ptr) + k;
      if (cand >= NB_MASTERS) begin
        cand = cand - NB_MASTERS;
      end
      if (req_i[cand]) begin
        win_idx   = MASTER_IDX_W'(cand);
        win_valid = 1'b1;
      end
    end
  end

  assign xfer = win_valid && slv.gnt;

  // request fields follow the winner, stable while the slot holds gnt low
  assign slv.req   = win_valid;
  assign slv.addr  = req_data_i[win_idx].addr;
  assign slv.wdata = req_data_i[win_idx].wdata;
  assign slv.we_n  = req_data_i[win_idx].we_n;
  assign slv.be    = req_data_i[win_idx].be;
  assign slv.id    = req_data_i[win_idx].id;

  always_comb begin
    gnt_o = '0;
    if (xfer) begin
      gnt_o[win_idx] = 1'b1;
    end
  end

  // next search starts just after the last winner
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_ptr <= '0;
    end else if (xfer) begin
      if (win_idx == MASTER_IDX_W'(NB_MASTERS - 1)) begin
        rr_ptr <= '0;
      end else begin
        rr_ptr <= win_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: periph_addr_decoder.sv
/*
 * Address decoder: maps a master address to a crossbar slot, covering the
 * cluster peripheral window, its alias, the external port and errors
 */
`timescale 1ns/1ps
`default_nettype none

module periph_addr_decoder (
  input  periph_xbar_pkg::periph_addr_t addr_i,
  input  logic [5:0]                    cluster_id_i,
  output periph_xbar_pkg::slot_idx_t    slot_o
);
  import periph_xbar_pkg::*;

  periph_addr_t cluster_base;
  periph_addr_t alias_base;
  periph_addr_t match_base;
  periph_addr_t win_lo;
  periph_addr_t win_hi;
  slot_idx_t    route;
  logic         hit_cluster;
  logic         hit_alias;
  logic         in_window;
  logic         bad_route;

  // each cluster owns a 4 MB region above the common base
  assign cluster_base = CLUSTER_BASE + (periph_addr_t'(cluster_id_i) << CLUSTER_ID_SHIFT);
  assign alias_base   = {ALIAS_BASE, 20'h0_0000};

  assign hit_cluster = (addr_i[31:24] == cluster_base[31:24]);
  assign hit_alias   = (addr_i[31:24] == ALIAS_BASE[11:4]);

  // the window is measured from whichever base the address hit
  assign match_base = hit_cluster ? cluster_base : alias_base;
  assign win_lo     = match_base + PERIPH_OFFS;
  assign win_hi     = match_base + EXT_OFFS;

  assign in_window = (hit_cluster || hit_alias) && (addr_i >= win_lo) && (addr_i < win_hi);

  assign route = addr_i[ROUTE_MSB:ROUTE_LSB];

  // stray bits above the routing field, missing ports, and a direct
  // hit on the external slot (would loop back out of the cluster)
  assign bad_route = (addr_i[19:ROUTE_MSB+1] != '0) ||
                     (route >= slot_idx_t'(NB_SLAVES)) ||
                     (route == slot_idx_t'(SLOT_EXT_ID));

  always_comb begin
    slot_o = slot_idx_t'(SLOT_EXT_ID);
    if (in_window) begin
      if (bad_route) begin
        slot_o = slot_idx_t'(SLOT_ERR_ID);
      end else if (route >= slot_idx_t'(SLOT_EU_ID) &&
                   route < slot_idx_t'(SLOT_EU_ID + EU_PLUGS)) begin
        // all event unit plugs share one port
        slot_o = slot_idx_t'(SLOT_EU_ID);
      end else begin
        slot_o = route;
      end
    end
  end

endmodule

`default_nettype wire

// File: periph_bus_if.sv
/*
 * Peripheral bus: request/grant level handshake plus tagged one-cycle
 * response, with a master and a slave view
 */
`timescale 1ns/1ps
`default_nettype none

interface periph_bus_if ();
  import periph_xbar_pkg::*;

  // request channel
  logic         req;
  logic         gnt;
  periph_addr_t addr;
  logic         we_n;
  periph_be_t   be;
  periph_data_t wdata;
  master_id_t   id;

  // response channel, r_valid is a single-cycle pulse
  logic         r_valid;
  periph_data_t r_rdata;
  logic         r_opc;
  master_id_t   r_id;

  modport master (
    output req, addr, we_n, be, wdata, id,
    input  gnt, r_valid, r_rdata, r_opc, r_id
  );

  modport slave (
    input  req, addr, we_n, be, wdata, id,
    output gnt, r_valid, r_rdata, r_opc, r_id
  );

endinterface

`default_nettype wire

// File: periph_xbar_pkg.sv
/*
 * Peripheral interconnect package: bus widths, slot numbering, the cluster
 * address map and the request/response structs shared by the crossbar
 */
`default_nettype none

package periph_xbar_pkg;

  // port counts
  localparam int NB_MASTERS   = 4;
  localparam int NB_SLAVES    = 8;
  // one extra slot behind the external ports for the error slave
  localparam int N_SLOTS      = NB_SLAVES + 1;
  localparam int MASTER_IDX_W = $clog2(NB_MASTERS);

  // bus widths
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int BE_WIDTH   = 4;

  // address bits that pick the peripheral inside the window
  localparam int ROUTE_LSB = 10;
  localparam int ROUTE_MSB = 13;

  // slot numbering
  localparam int SLOT_EXT_ID = 7;
  localparam int SLOT_EU_ID  = 2;
  // event unit occupies this many consecutive routing slots
  localparam int EU_PLUGS    = 2;
  localparam int SLOT_ERR_ID = NB_SLAVES;

  // cluster address map
  localparam logic [ADDR_WIDTH-1:0] CLUSTER_BASE = 32'h5000_0000;
  localparam logic [ADDR_WIDTH-1:0] PERIPH_OFFS  = 32'h0020_0000;
  localparam logic [ADDR_WIDTH-1:0] EXT_OFFS     = 32'h0040_0000;
  // upper 12 address bits of the alias region
  localparam logic [11:0]           ALIAS_BASE   = 12'h000;
  localparam int                    CLUSTER_ID_SHIFT = 22;

  // read data returned for any decode error
  localparam logic [DATA_WIDTH-1:0] ERR_RDATA = 32'hbad0_acce;

  // basic bus types
  typedef logic [ADDR_WIDTH-1:0] periph_addr_t;
  typedef logic [DATA_WIDTH-1:0] periph_data_t;
  typedef logic [BE_WIDTH-1:0]   periph_be_t;
  typedef logic [NB_MASTERS-1:0] master_id_t;
  typedef logic [3:0]            slot_idx_t;

  // request as seen by a slot arbiter
  typedef struct packed {
    periph_addr_t addr;
    periph_data_t wdata;
    logic         we_n;
    periph_be_t   be;
    master_id_t   id;
  } periph_req_t;

  // response as collected from a slot
  typedef struct packed {
    periph_data_t rdata;
    logic         opc;
    master_id_t   id;
  } periph_resp_t;

endpackage

`default_nettype wire
